// File: files.f
+incdir+include
logic/exePkg.sv
logic/aluOpDecode.sv
logic/intAlu.sv
logic/mulDivUnit.sv
logic/resultMerge.sv
logic/exeUnit.sv
test/exeUnit_asserts.sv
test/exeUnitTb.sv

// File: include/exe_macros.svh
// exe macros give the widths, opcode codes and multiply selectors of the execute stage
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

`define EXE_XLEN      64
`define EXE_ALUOP_W   5
`define EXE_MULOP_W   2
`define EXE_MD_STEPS  64

// bit 4 set marks a W form
`define EXE_OP_ADD    5'b00000
`define EXE_OP_ADDW   5'b10000
`define EXE_OP_SLL    5'b00001
`define EXE_OP_SLLW   5'b10001
`define EXE_OP_SLT    5'b00010
`define EXE_OP_SLTU   5'b00011
`define EXE_OP_XOR    5'b00100
`define EXE_OP_SRL    5'b00101
`define EXE_OP_SRLW   5'b10101
`define EXE_OP_OR     5'b00110
`define EXE_OP_AND    5'b00111
`define EXE_OP_SUB    5'b01000
`define EXE_OP_SUBW   5'b11000
`define EXE_OP_SRA    5'b01101
`define EXE_OP_SRAW   5'b11101
`define EXE_OP_PASSB  5'b01111
`define EXE_OP_MUL    5'b01001
`define EXE_OP_MULW   5'b11001
`define EXE_OP_DIVU   5'b01010
`define EXE_OP_DIV    5'b01011
`define EXE_OP_DIVUW  5'b11010
`define EXE_OP_DIVW   5'b11011
`define EXE_OP_REMU   5'b01100
`define EXE_OP_REM    5'b01110
`define EXE_OP_REMUW  5'b11100
`define EXE_OP_REMW   5'b11110

// product half selectors
`define EXE_MUL_LO    2'b00
`define EXE_MUL_HU    2'b01
`define EXE_MUL_HSU   2'b10
`define EXE_MUL_HS    2'b11

`endif

// File: logic/aluOpDecode.sv
// aluOpDecode turns the opcode into datapath controls and splits issue into unit starts
`timescale 1ns/1ns
`include "exe_macros.svh"

module aluOpDecode (
    input  logic            issueValid,
    input  logic            busy,
    input  exePkg::aluOpT   aluOp,
    output exePkg::opClassT opClass,
    output logic            subCtl,
    output logic            signedCtl,
    output logic            arithCtl,
    output logic            rightCtl,
    output logic            wordCtl,
    output logic            aluStart,
    output logic            mdStart
);

    // class, then sub, signed, arith, right, word
    logic [8:0] ctl;
    logic       isMd;

    always_comb begin
        case (aluOp)
            `EXE_OP_ADD:   ctl = {exePkg::clsAdd,   5'b00000};
            `EXE_OP_ADDW:  ctl = {exePkg::clsAdd,   5'b00001};
            `EXE_OP_SUB:   ctl = {exePkg::clsAdd,   5'b10000};
            `EXE_OP_SUBW:  ctl = {exePkg::clsAdd,   5'b10001};
            `EXE_OP_SLL:   ctl = {exePkg::clsShift, 5'b00000};
            `EXE_OP_SLLW:  ctl = {exePkg::clsShift, 5'b00001};
            `EXE_OP_SRL:   ctl = {exePkg::clsShift, 5'b00010};
            `EXE_OP_SRLW:  ctl = {exePkg::clsShift, 5'b00011};
            `EXE_OP_SRA:   ctl = {exePkg::clsShift, 5'b00110};
            `EXE_OP_SRAW:  ctl = {exePkg::clsShift, 5'b00111};
            `EXE_OP_SLT:   ctl = {exePkg::clsCmp,   5'b11000};
            `EXE_OP_SLTU:  ctl = {exePkg::clsCmp,   5'b10000};
            `EXE_OP_XOR:   ctl = {exePkg::clsXor,   5'b00000};
            `EXE_OP_OR:    ctl = {exePkg::clsOr,    5'b00000};
            `EXE_OP_AND:   ctl = {exePkg::clsAnd,   5'b00000};
            `EXE_OP_PASSB: ctl = {exePkg::clsPassB, 5'b00000};
            `EXE_OP_MUL:   ctl = {exePkg::clsMul,   5'b00000};
            `EXE_OP_MULW:  ctl = {exePkg::clsMul,   5'b00001};
            `EXE_OP_DIVU:  ctl = {exePkg::clsDiv,   5'b00000};
            `EXE_OP_DIV:   ctl = {exePkg::clsDiv,   5'b01000};
            `EXE_OP_DIVUW: ctl = {exePkg::clsDiv,   5'b00001};
            `EXE_OP_DIVW:  ctl = {exePkg::clsDiv,   5'b01001};
            `EXE_OP_REMU:  ctl = {exePkg::clsRem,   5'b00000};
            `EXE_OP_REM:   ctl = {exePkg::clsRem,   5'b01000};
            `EXE_OP_REMUW: ctl = {exePkg::clsRem,   5'b00001};
            `EXE_OP_REMW:  ctl = {exePkg::clsRem,   5'b01001};
            default:       ctl = {exePkg::clsAdd,   5'b00000}; // unknown runs as add
        endcase
    end

    assign opClass   = exePkg::opClassT'(ctl[8:5]);
    assign subCtl    = ctl[4];
    assign signedCtl = ctl[3];
    assign arithCtl  = ctl[2];
    assign rightCtl  = ctl[1];
    assign wordCtl   = ctl[0];

    assign isMd = (opClass == exePkg::clsMul) || (opClass == exePkg::clsDiv)
               || (opClass == exePkg::clsRem);

    // an issue while the md unit is busy is dropped here
    assign aluStart = issueValid && !busy && !isMd;
    assign mdStart  = issueValid && !busy && isMd;

endmodule

// File: logic/exePkg.sv
// exePkg holds the word types and controller enums of the execute stage
`include "exe_macros.svh"

package exePkg;

    typedef logic [`EXE_XLEN-1:0]    xlenT;
    typedef logic [`EXE_ALUOP_W-1:0] aluOpT;
    typedef logic [`EXE_MULOP_W-1:0] mulOpT;

    // result class picked by the decoder
    typedef enum logic [3:0] {
        clsAdd   = 4'd0,
        clsAnd   = 4'd1,
        clsOr    = 4'd2,
        clsXor   = 4'd3,
        clsShift = 4'd4,
        clsPassB = 4'd5,
        clsCmp   = 4'd6,
        clsMul   = 4'd7,
        clsDiv   = 4'd8,
        clsRem   = 4'd9
    } opClassT;

    typedef enum logic [1:0] {
        mdIdle,
        mdRun,
        mdFix
    } mdStateT;

endpackage

// File: logic/exeUnit.sv
// exeUnit is the integer execute stage, ALU and multiply/divide unit behind one result port
`timescale 1ns/1ns

module exeUnit (
    input  logic          clock,
    input  logic          rst,
    input  logic          issueValid,
    input  exePkg::aluOpT aluOp,
    input  exePkg::mulOpT mulOp,
    input  exePkg::xlenT  srcA,
    input  exePkg::xlenT  srcB,
    output logic          busy,
    output logic          resultValid,
    output exePkg::xlenT  result,
    output logic          zero
);

    exePkg::opClassT opClass;
    logic            subCtl;
    logic            signedCtl;
    logic            arithCtl;
    logic            rightCtl;
    logic            wordCtl;
    logic            aluStart;
    logic            mdStart;
    exePkg::xlenT    aluResult;
    logic            aluZero;
    logic            mdDone;
    exePkg::xlenT    mdResult;

    aluOpDecode uDecode (
        .issueValid(issueValid), .busy(busy), .aluOp(aluOp), .opClass(opClass),
        .subCtl(subCtl), .signedCtl(signedCtl), .arithCtl(arithCtl),
        .rightCtl(rightCtl), .wordCtl(wordCtl), .aluStart(aluStart), .mdStart(mdStart)
    );

    intAlu uAlu (
        .srcA(srcA), .srcB(srcB), .opClass(opClass), .subCtl(subCtl),
        .signedCtl(signedCtl), .arithCtl(arithCtl), .rightCtl(rightCtl),
        .wordCtl(wordCtl), .aluResult(aluResult), .aluZero(aluZero)
    );

    mulDivUnit uMulDiv (
        .clock(clock), .rst(rst), .mdStart(mdStart), .srcA(srcA), .srcB(srcB),
        .opClass(opClass), .signedCtl(signedCtl), .wordCtl(wordCtl), .mulOp(mulOp),
        .busy(busy), .mdDone(mdDone), .mdResult(mdResult)
    );

    resultMerge uMerge (
        .clock(clock), .rst(rst), .aluStart(aluStart), .aluResult(aluResult),
        .aluZero(aluZero), .mdDone(mdDone), .mdResult(mdResult),
        .resultValid(resultValid), .result(result), .zero(zero)
    );

endmodule

// File: logic/intAlu.sv
// intAlu is the single-cycle adder, logic, shift and compare datapath
`timescale 1ns/1ns
`include "exe_macros.svh"

module intAlu (
    input  exePkg::xlenT    srcA,
    input  exePkg::xlenT    srcB,
    input  exePkg::opClassT opClass,
    input  logic            subCtl,
    input  logic            signedCtl,
    input  logic            arithCtl,
    input  logic            rightCtl,
    input  logic            wordCtl,
    output exePkg::xlenT    aluResult,
    output logic            aluZero
);

    localparam int XLen = `EXE_XLEN;

    exePkg::xlenT       addB;
    exePkg::xlenT       addSum;
    exePkg::xlenT       addRes;
    logic               carryOut;
    logic               carryF;
    logic               signF;
    logic               ovF;
    logic               lessThan;
    logic [31:0]        sllW;
    logic [31:0]        srW;
    logic signed [31:0] sraW;
    logic signed [XLen-1:0] sra64;
    exePkg::xlenT       sr64;
    exePkg::xlenT       shiftL;
    exePkg::xlenT       shiftR;
    exePkg::xlenT       shiftRes;

    // subtract as A + ~B + 1
    assign addB = srcB ^ {XLen{subCtl}};
    assign {carryOut, addSum} = {1'b0, srcA} + {1'b0, addB} + {{XLen{1'b0}}, subCtl};

    assign carryF  = carryOut ^ subCtl;   // borrow on sub
    assign signF   = addSum[XLen-1];
    assign ovF     = (srcA[XLen-1] == addB[XLen-1]) && (addSum[XLen-1] != srcA[XLen-1]);
    assign aluZero = (addSum == '0);

    assign addRes = wordCtl ? {{(XLen-32){addSum[31]}}, addSum[31:0]} : addSum;

    // W shifts take 5 amount bits, full shifts 6
    assign sllW  = srcA[31:0] << srcB[4:0];
    assign sraW  = $signed(srcA[31:0]) >>> srcB[4:0];
    assign sra64 = $signed(srcA) >>> srcB[5:0];
    assign srW   = arithCtl ? sraW : (srcA[31:0] >> srcB[4:0]);
    assign sr64  = arithCtl ? sra64 : (srcA >> srcB[5:0]);

    assign shiftL   = wordCtl ? {{(XLen-32){sllW[31]}}, sllW} : (srcA << srcB[5:0]);
    assign shiftR   = wordCtl ? {{(XLen-32){srW[31]}}, srW} : sr64;
    assign shiftRes = rightCtl ? shiftR : shiftL;

    assign lessThan = signedCtl ? (ovF ^ signF) : carryF;

    always_comb begin
        case (opClass)
            exePkg::clsAnd:   aluResult = srcA & srcB;
            exePkg::clsOr:    aluResult = srcA | srcB;
            exePkg::clsXor:   aluResult = srcA ^ srcB;
            exePkg::clsShift: aluResult = shiftRes;
            exePkg::clsPassB: aluResult = srcB;
            exePkg::clsCmp:   aluResult = {{(XLen-1){1'b0}}, lessThan};
            default:          aluResult = addRes;  // add and sub
        endcase
    end

endmodule

// File: logic/mulDivUnit.sv
// mulDivUnit runs a 64-step shift-add multiply or restoring divide with sign fix-up
`timescale 1ns/1ns
`include "exe_macros.svh"

module mulDivUnit (
    input  logic            clock,
    input  logic            rst,
    input  logic            mdStart,
    input  exePkg::xlenT    srcA,
    input  exePkg::xlenT    srcB,
    input  exePkg::opClassT opClass,
    input  logic            signedCtl,
    input  logic            wordCtl,
    input  exePkg::mulOpT   mulOp,
    output logic            busy,
    output logic            mdDone,
    output exePkg::xlenT    mdResult
);

    localparam int XLen = `EXE_XLEN;
    localparam int CntW = $clog2(`EXE_MD_STEPS);

    exePkg::mdStateT   state;
    logic [CntW-1:0]   stepCnt;

    exePkg::opClassT   opReg;
    exePkg::mulOpT     mulOpReg;
    logic              wordReg;
    logic              negRes;
    logic [2*XLen-1:0] acc;      // hi is remainder or product high
    exePkg::xlenT      opB;      // multiplicand or divisor magnitude

    logic              isMul;
    logic              sgnA;
    logic              sgnB;
    logic              negA;
    logic              negB;
    logic              negLoad;
    exePkg::xlenT      extA;
    exePkg::xlenT      extB;
    exePkg::xlenT      magA;
    exePkg::xlenT      magB;

    logic [XLen:0]     mulSum;
    logic [XLen:0]     divUp;
    logic [XLen:0]     divDiff;
    logic              divGe;

    logic [2*XLen-1:0] prod;
    exePkg::xlenT      quot;
    exePkg::xlenT      remd;
    exePkg::xlenT      selRes;
    exePkg::xlenT      fixRes;

    // signedness per operand
    assign isMul = (opClass == exePkg::clsMul);
    assign sgnA  = isMul ? (mulOp == `EXE_MUL_HS || mulOp == `EXE_MUL_HSU) : signedCtl;
    assign sgnB  = isMul ? (mulOp == `EXE_MUL_HS) : signedCtl;

    assign extA = wordCtl ? {{(XLen-32){sgnA & srcA[31]}}, srcA[31:0]} : srcA;
    assign extB = wordCtl ? {{(XLen-32){sgnB & srcB[31]}}, srcB[31:0]} : srcB;
    assign negA = sgnA & extA[XLen-1];
    assign negB = sgnB & extB[XLen-1];
    assign magA = negA ? -extA : extA;
    assign magB = negB ? -extB : extB;

    // a zero divisor keeps the quotient all ones
    assign negLoad = (opClass == exePkg::clsRem) ? negA
                   : (negA ^ negB) & (isMul | (extB != '0));

    assign mulSum  = {1'b0, acc[2*XLen-1:XLen]} + (acc[0] ? {1'b0, opB} : '0);
    assign divUp   = acc[2*XLen-1:XLen-1];   // partial remainder shifted in
    assign divGe   = (divUp >= {1'b0, opB});
    assign divDiff = divUp - {1'b0, opB};

    assign prod = negRes ? -acc : acc;
    assign quot = negRes ? -acc[XLen-1:0] : acc[XLen-1:0];
    assign remd = negRes ? -acc[2*XLen-1:XLen] : acc[2*XLen-1:XLen];

    always_comb begin
        case (opReg)
            exePkg::clsDiv: selRes = quot;
            exePkg::clsRem: selRes = remd;
            default: selRes = (mulOpReg == `EXE_MUL_LO || wordReg) ? prod[XLen-1:0]
                                                                   : prod[2*XLen-1:XLen];
        endcase
    end

    assign fixRes = wordReg ? {{(XLen-32){selRes[31]}}, selRes[31:0]} : selRes;

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= exePkg::mdIdle;
            stepCnt <= '0;
            mdDone  <= 1'b0;
        end else begin
            mdDone <= 1'b0;
            case (state)
                exePkg::mdIdle: begin
                    if (mdStart) begin
                        state   <= exePkg::mdRun;
                        stepCnt <= '0;
                    end
                end
                exePkg::mdRun: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == CntW'(`EXE_MD_STEPS - 1))
                        state <= exePkg::mdFix;
                end
                exePkg::mdFix: begin
                    state  <= exePkg::mdIdle;
                    mdDone <= 1'b1;
                end
                default: state <= exePkg::mdIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == exePkg::mdIdle && mdStart) begin
            opReg    <= opClass;
            mulOpReg <= mulOp;
            wordReg  <= wordCtl;
            negRes   <= negLoad;
            acc      <= {{XLen{1'b0}}, magA};
            opB      <= magB;
        end else if (state == exePkg::mdRun) begin
            if (opReg == exePkg::clsMul)
                acc <= {mulSum, acc[XLen-1:1]};
            else
                acc <= {divGe ? divDiff[XLen-1:0] : divUp[XLen-1:0], acc[XLen-2:0], divGe};
        end else if (state == exePkg::mdFix) begin
            mdResult <= fixRes;
        end
    end

    // held through the done cycle so nothing issues onto the merge slot
    assign busy = (state != exePkg::mdIdle) || mdDone;

endmodule

// File: logic/resultMerge.sv
// resultMerge registers the ALU or multiply/divide result onto one valid/result/zero port
`timescale 1ns/1ns

module resultMerge (
    input  logic         clock,
    input  logic         rst,
    input  logic         aluStart,
    input  exePkg::xlenT aluResult,
    input  logic         aluZero,
    input  logic         mdDone,
    input  exePkg::xlenT mdResult,
    output logic         resultValid,
    output exePkg::xlenT result,
    output logic         zero
);

    always_ff @(posedge clock) begin
        if (rst) begin
            resultValid <= 1'b0;
            result      <= '0;
            zero        <= 1'b0;
        end else begin
            resultValid <= aluStart || mdDone;   // one-cycle pulse
            if (aluStart) begin
                result <= aluResult;
                zero   <= aluZero;
            end else if (mdDone) begin
                result <= mdResult;
                zero   <= 1'b0;   // no flag for md results
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f files.f --top-module exeUnitTb -o exeUnitSim

./obj_dir/exeUnitSim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/exeUnitTb.sv
// exeUnitTb checks the execute stage against a reference model with corner and LCG operands
`timescale 1ns/1ns
`include "exe_macros.svh"

module exeUnitTb;

    localparam int Period     = 4;
    localparam int RstCycles  = 16;
    localparam int NumCorner  = 5;
    localparam int NumRand    = 6;
    localparam int PerOp      = NumCorner * NumCorner + NumRand;
    localparam int NumOps     = 29 * PerOp + 19;
    localparam int MdLat      = `EXE_MD_STEPS + 2;
    localparam int WatchdogNs = (NumOps * (`EXE_MD_STEPS + 4) + RstCycles) * Period;

    localparam exePkg::xlenT Corners [NumCorner] = '{
        64'h0, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000, 64'h1,
        64'hFFFF_FFFF_8000_0000   // most negative W value
    };
    localparam exePkg::aluOpT AluOps [16] = '{
        `EXE_OP_ADD, `EXE_OP_ADDW, `EXE_OP_SUB, `EXE_OP_SUBW, `EXE_OP_SLL, `EXE_OP_SLLW,
        `EXE_OP_SRL, `EXE_OP_SRLW, `EXE_OP_SRA, `EXE_OP_SRAW, `EXE_OP_SLT, `EXE_OP_SLTU,
        `EXE_OP_XOR, `EXE_OP_OR, `EXE_OP_AND, `EXE_OP_PASSB
    };
    localparam exePkg::aluOpT MdOps [13] = '{
        `EXE_OP_MUL, `EXE_OP_MUL, `EXE_OP_MUL, `EXE_OP_MUL, `EXE_OP_MULW,
        `EXE_OP_DIV, `EXE_OP_DIVU, `EXE_OP_REM, `EXE_OP_REMU,
        `EXE_OP_DIVW, `EXE_OP_DIVUW, `EXE_OP_REMW, `EXE_OP_REMUW
    };
    localparam exePkg::mulOpT MdMulOps [13] = '{
        `EXE_MUL_LO, `EXE_MUL_HU, `EXE_MUL_HSU, `EXE_MUL_HS, `EXE_MUL_HSU,
        `EXE_MUL_LO, `EXE_MUL_LO, `EXE_MUL_LO, `EXE_MUL_LO,
        `EXE_MUL_LO, `EXE_MUL_LO, `EXE_MUL_LO, `EXE_MUL_LO
    };

    logic          clock;
    logic          rst;
    logic          issueValid;
    exePkg::aluOpT aluOp;
    exePkg::mulOpT mulOp;
    exePkg::xlenT  srcA;
    exePkg::xlenT  srcB;
    logic          busy;
    logic          resultValid;
    exePkg::xlenT  result;
    logic          zero;
    logic [64:0]   expQ [$];   // {zero, result} in issue order
    logic [63:0]   lcgState;

    exeUnit u_dut (.*);

    always #(Period / 2) clock = ~clock;

    function automatic exePkg::xlenT randWord();
        lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcgState ^ (lcgState >> 29);
    endfunction

    function automatic exePkg::xlenT sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // RISC-V divide rules, zero divisor and overflow first
    function automatic exePkg::xlenT divRef(input exePkg::xlenT a, input exePkg::xlenT b,
                                            input logic sgn, input logic word, input logic rem);
        exePkg::xlenT x;
        exePkg::xlenT y;
        exePkg::xlenT q;
        exePkg::xlenT r;
        x = word ? (sgn ? sext32(a[31:0]) : {32'd0, a[31:0]}) : a;
        y = word ? (sgn ? sext32(b[31:0]) : {32'd0, b[31:0]}) : b;
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (sgn && x == 64'h8000_0000_0000_0000 && y == '1) begin
            q = x;
            r = '0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        q = rem ? r : q;
        return word ? sext32(q[31:0]) : q;
    endfunction

    function automatic logic [64:0] refModel(input exePkg::aluOpT op, input exePkg::mulOpT mop,
                                             input exePkg::xlenT a, input exePkg::xlenT b);
        exePkg::xlenT r;
        exePkg::xlenT sum;
        exePkg::xlenT diff;
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] p;
        logic [31:0]  m32;
        logic         z;
        sum  = a + b;
        diff = a - b;
        ea   = {{64{a[63] & (mop == `EXE_MUL_HS || mop == `EXE_MUL_HSU)}}, a};
        eb   = {{64{b[63] & (mop == `EXE_MUL_HS)}}, b};
        p    = ea * eb;
        m32  = a[31:0] * b[31:0];
        case (op)
            `EXE_OP_ADDW:  r = sext32(sum[31:0]);
            `EXE_OP_SUB:   r = diff;
            `EXE_OP_SUBW:  r = sext32(diff[31:0]);
            `EXE_OP_SLL:   r = a << b[5:0];
            `EXE_OP_SLLW:  r = sext32(a[31:0] << b[4:0]);
            `EXE_OP_SRL:   r = a >> b[5:0];
            `EXE_OP_SRLW:  r = sext32(a[31:0] >> b[4:0]);
            `EXE_OP_SRA:   r = $signed(a) >>> b[5:0];
            `EXE_OP_SRAW:  r = sext32($signed(a[31:0]) >>> b[4:0]);
            `EXE_OP_SLT:   r = {63'd0, $signed(a) < $signed(b)};
            `EXE_OP_SLTU:  r = {63'd0, a < b};
            `EXE_OP_XOR:   r = a ^ b;
            `EXE_OP_OR:    r = a | b;
            `EXE_OP_AND:   r = a & b;
            `EXE_OP_PASSB: r = b;
            `EXE_OP_MUL:   r = (mop == `EXE_MUL_LO) ? p[63:0] : p[127:64];
            `EXE_OP_MULW:  r = sext32(m32);
            `EXE_OP_DIV:   r = divRef(a, b, 1'b1, 1'b0, 1'b0);
            `EXE_OP_DIVU:  r = divRef(a, b, 1'b0, 1'b0, 1'b0);
            `EXE_OP_REM:   r = divRef(a, b, 1'b1, 1'b0, 1'b1);
            `EXE_OP_REMU:  r = divRef(a, b, 1'b0, 1'b0, 1'b1);
            `EXE_OP_DIVW:  r = divRef(a, b, 1'b1, 1'b1, 1'b0);
            `EXE_OP_DIVUW: r = divRef(a, b, 1'b0, 1'b1, 1'b0);
            `EXE_OP_REMW:  r = divRef(a, b, 1'b1, 1'b1, 1'b1);
            `EXE_OP_REMUW: r = divRef(a, b, 1'b0, 1'b1, 1'b1);
            default:       r = sum;   // add and unknown codes
        endcase
        case (op)
            `EXE_OP_SUB, `EXE_OP_SUBW, `EXE_OP_SLT, `EXE_OP_SLTU: z = (diff == '0);
            `EXE_OP_MUL, `EXE_OP_MULW, `EXE_OP_DIV, `EXE_OP_DIVU, `EXE_OP_REM,
            `EXE_OP_REMU, `EXE_OP_DIVW, `EXE_OP_DIVUW, `EXE_OP_REMW, `EXE_OP_REMUW: z = 1'b0;
            default: z = (sum == '0);
        endcase
        return {z, r};
    endfunction

    task automatic failStop();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic applyInputs(input logic valid, input exePkg::aluOpT op,
                               input exePkg::mulOpT mop, input exePkg::xlenT a,
                               input exePkg::xlenT b);
        @(posedge clock);
        #1;
        issueValid = valid;
        aluOp      = op;
        mulOp      = mop;
        srcA       = a;
        srcB       = b;
    endtask

    // lat counts edges after the issue edge
    task automatic waitResult(input int expLat, input logic md);
        int lat;
        lat = 0;
        @(negedge clock);
        while (!resultValid && lat < MdLat + 4) begin
            assert (!md || busy) else begin
                $display("busy dropped while a multiply/divide operation was running");
                failStop();
            end
            @(negedge clock);
            lat++;
        end
        assert (resultValid) else begin
            $display("no result arrived within the expected time");
            failStop();
        end
        assert (lat == expLat) else begin
            $display("result arrived %0d cycles after issue instead of %0d", lat, expLat);
            failStop();
        end
        assert (!busy) else begin
            $display("busy still high in the result cycle");
            failStop();
        end
    endtask

    task automatic runOp(input exePkg::aluOpT op, input exePkg::mulOpT mop,
                         input exePkg::xlenT a, input exePkg::xlenT b, input logic md);
        expQ.push_back(refModel(op, mop, a, b));
        applyInputs(1'b1, op, mop, a, b);
        applyInputs(1'b0, op, mop, a, b);
        waitResult(md ? MdLat : 0, md);
    endtask

    task automatic runSet(input exePkg::aluOpT op, input exePkg::mulOpT mop, input logic md);
        exePkg::xlenT a;
        exePkg::xlenT b;
        for (int i = 0; i < NumCorner; i++) begin
            for (int j = 0; j < NumCorner; j++)
                runOp(op, mop, Corners[i], Corners[j], md);
        end
        repeat (NumRand) begin
            a = randWord();
            b = randWord();
            runOp(op, mop, a, b, md);
        end
    endtask

    always @(negedge clock) begin
        logic [64:0] want;
        if (!rst && resultValid) begin
            assert (expQ.size() != 0) else begin
                $display("a result appeared with no operation outstanding");
                failStop();
            end
            want = expQ.pop_front();
            assert (result == want[63:0]) else begin
                $display("error: result got %h expected %h", result, want[63:0]);
                failStop();
            end
            assert (zero == want[64]) else begin
                $display("error: zero got %h expected %h", zero, want[64]);
                failStop();
            end
        end
    end

    initial begin
        #(WatchdogNs);
        $display("watchdog expired before all operations completed");
        failStop();
    end

    initial begin
        exePkg::xlenT a;
        exePkg::xlenT b;
        clock      = 1'b0;
        rst        = 1'b1;
        issueValid = 1'b0;
        aluOp      = `EXE_OP_ADD;
        mulOp      = `EXE_MUL_LO;
        srcA       = '0;
        srcB       = '0;
        lcgState   = 64'd83860;
        repeat (RstCycles) @(posedge clock);
        #1;
        rst = 1'b0;
        @(negedge clock);
        assert (!busy && !resultValid && !zero && result == '0) else begin
            $display("error: after reset busy %h resultValid %h zero %h result %h",
                     busy, resultValid, zero, result);
            failStop();
        end

        for (int i = 0; i < 16; i++)
            runSet(AluOps[i], `EXE_MUL_LO, 1'b0);
        for (int i = 0; i < 13; i++)
            runSet(MdOps[i], MdMulOps[i], 1'b1);

        // one ALU issue per cycle, results one cycle behind
        for (int i = 0; i < 16; i++) begin
            a = randWord();
            b = randWord();
            expQ.push_back(refModel(AluOps[i], `EXE_MUL_LO, a, b));
            applyInputs(1'b1, AluOps[i], `EXE_MUL_LO, a, b);
            if (i > 0) begin
                @(negedge clock);
                assert (resultValid) else begin
                    $display("a back-to-back ALU result was missing");
                    failStop();
                end
            end
        end
        applyInputs(1'b0, `EXE_OP_ADD, `EXE_MUL_LO, a, b);
        @(negedge clock);
        assert (resultValid) else begin
            $display("the last back-to-back ALU result was missing");
            failStop();
        end
        @(negedge clock);
        assert (expQ.size() == 0) else begin
            $display("back-to-back results were lost");
            failStop();
        end

        // overflow divide, then two issues that land while busy
        a = 64'h8000_0000_0000_0000;
        b = '1;
        expQ.push_back(refModel(`EXE_OP_DIV, `EXE_MUL_LO, a, b));
        applyInputs(1'b1, `EXE_OP_DIV, `EXE_MUL_LO, a, b);
        repeat (4) applyInputs(1'b0, `EXE_OP_DIV, `EXE_MUL_LO, a, b);
        applyInputs(1'b1, `EXE_OP_ADD, `EXE_MUL_LO, Corners[3], b);
        applyInputs(1'b1, `EXE_OP_MUL, `EXE_MUL_HS, a, b);
        applyInputs(1'b0, `EXE_OP_ADD, `EXE_MUL_LO, a, b);
        waitResult(MdLat - 6, 1'b1);
        repeat (4) @(negedge clock);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: test/exeUnit_asserts.sv
// exeUnitAsserts checks issue gating and result timing of the execute stage
`timescale 1ns/1ns

module exeUnitAsserts (
    input logic clock,
    input logic rst,
    input logic issueValid,
    input logic busy,
    input logic resultValid,
    input logic aluStart,
    input logic mdDone
);

    // a result pulse seen while busy is gone the next cycle
    assert property (@(posedge clock) disable iff (rst) (resultValid && busy) |=> !resultValid)
        else $error("resultValid held for two cycles while busy");

    assert property (@(posedge clock) rst |=> (!busy && !resultValid))
        else $error("busy or resultValid high during reset");

    // the done cycle already owns the next result slot
    assert property (@(posedge clock) disable iff (rst)
        (issueValid && busy && !mdDone) |=> !resultValid)
        else $error("a result followed an issue made while busy");

    assert property (@(posedge clock) disable iff (rst) aluStart |=> resultValid)
        else $error("no resultValid in the cycle after an ALU issue");

endmodule

bind exeUnit exeUnitAsserts uAsserts (
    .clock(clock), .rst(rst), .issueValid(issueValid), .busy(busy),
    .resultValid(resultValid), .aluStart(aluStart), .mdDone(mdDone)
);
